/* build.f */
logic/edge_pkg.sv
logic/edge_read_sequencer.sv
logic/response_router.sv
logic/cacheline_stream.sv
logic/edge_assembler.sv
logic/edge_job_fifo.sv
logic/edge_fetch_top.sv
tests/edge_fetch_props.sv
tests/edge_fetch_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= edge_fetch_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/edge_fetch_tb.sv */
`timescale 1ns/1ns

module edge_fetch_tb;

	typedef struct packed {
		logic [31:0] edges_idx;
		logic [15:0] degree;
		logic        req_random;    // edge_request in long random stretches
		logic        rbf_toggle;    // read_buffer_full noise
		logic [7:0]  chunks;        // expected line chunks
	} row_t;

	localparam int row_count = 10;
	localparam int mem_words = 256;

	row_t rows [row_count] = '{
		'{32'd32,  16'd40, 1'b0, 1'b0, 8'd3},    // aligned
		'{32'd5,   16'd7,  1'b0, 1'b0, 8'd1},
		'{32'd13,  16'd20, 1'b0, 1'b0, 8'd3},
		'{32'd0,   16'd0,  1'b0, 1'b0, 8'd0},    // empty vertex
		'{32'd100, 16'd60, 1'b1, 1'b1, 8'd4},
		'{32'd200, 16'd50, 1'b1, 1'b1, 8'd4},
		'{32'd7,   16'd1,  1'b0, 1'b1, 8'd1},
		'{32'd64,  16'd33, 1'b1, 1'b0, 8'd3},
		'{32'd150, 16'd45, 1'b1, 1'b1, 8'd4},
		'{32'd31,  16'd2,  1'b0, 1'b1, 8'd2}
	};

	logic                    clock = 1'b0;
	logic                    rstn = 1'b0;
	edge_pkg::fetch_config_t cfg;
	edge_pkg::vertex_job_t   vertex_job;
	logic                    vertex_job_request;
	edge_pkg::read_cmd_t     read_cmd;
	logic                    read_buffer_full;
	edge_pkg::read_resp_t    read_resp;
	logic                    edge_request;
	edge_pkg::edge_job_t     edge_job;
	logic                    edge_buffer_empty;

	logic [31:0]         mem [3][mem_words];    // src, dest, weight arrays
	integer              seed;
	edge_pkg::read_cmd_t exp_cmds [$];
	edge_pkg::edge_job_t exp_edges [$];
	edge_pkg::read_cmd_t pend_cmds [$];         // memory model backlog
	int                  pend_due [$];
	int                  cycles = 0;
	int                  cycle_limit;
	int                  errors = 0;
	int                  checks = 0;
	int                  cmds_seen = 0;
	int                  next_id = 0;
	int                  req_hold = 0;
	logic                req_random = 1'b0;
	logic                rbf_toggle = 1'b0;

	initial begin
		forever #50 clock = ~clock;
	end

	edge_fetch_top dut_i (
		.clock              (clock),
		.rstn               (rstn),
		.cfg                (cfg),
		.vertex_job         (vertex_job),
		.vertex_job_request (vertex_job_request),
		.read_cmd           (read_cmd),
		.read_buffer_full   (read_buffer_full),
		.read_resp          (read_resp),
		.edge_request       (edge_request),
		.edge_job           (edge_job),
		.edge_buffer_empty  (edge_buffer_empty)
	);

	function automatic logic [47:0] base_of(input edge_pkg::edge_array_t array);
		case (array)
			edge_pkg::array_src:  return cfg.src_base;
			edge_pkg::array_dest: return cfg.dest_base;
			default:              return cfg.weight_base;
		endcase
	endfunction

	// full line from the array named in the tag
	function automatic edge_pkg::read_resp_t line_response(input edge_pkg::read_cmd_t cmd);
		edge_pkg::read_resp_t resp;
		int                   a;
		int                   word;
		a          = int'(cmd.tag.array);
		word       = int'((cmd.address - base_of(cmd.tag.array)) >> 2);
		resp.valid = 1'b1;
		resp.tag   = cmd.tag;
		for (int k = 0; k < 16; k++)
			resp.data[32*k +: 32] = mem[a][(word + k) % mem_words];
		return resp;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// expected commands and edges of one vertex job
	////////////////////////////////////////////////////////////////////////////
	task automatic expect_row(input row_t row);
		int                  idx;
		int                  n;
		int                  r;
		int                  cnt;
		edge_pkg::read_cmd_t cmd;
		edge_pkg::edge_job_t e;
		idx = int'(row.edges_idx);
		n   = int'(row.degree);
		while (n > 0) begin
			r   = idx % edge_pkg::line_edges;
			cnt = (edge_pkg::line_edges - r < n) ? edge_pkg::line_edges - r : n;
			for (int a = 0; a < 3; a++) begin
				cmd.valid      = 1'b1;
				cmd.op         = edge_pkg::op_read_line;
				cmd.address    = (base_of(edge_pkg::edge_array_t'(a)) + 48'(idx) * 4) & ~48'h3f;
				cmd.tag.array  = edge_pkg::edge_array_t'(a);
				cmd.tag.offset = 4'(r);
				cmd.tag.count  = 5'(cnt);
				exp_cmds.push_back(cmd);
			end
			idx += cnt;
			n   -= cnt;
		end
		for (int k = 0; k < int'(row.degree); k++) begin
			e.valid  = 1'b1;
			e.id     = 16'(next_id);
			e.src    = mem[0][int'(row.edges_idx) + k];
			e.dest   = mem[1][int'(row.edges_idx) + k];
			e.weight = mem[2][int'(row.edges_idx) + k];
			exp_edges.push_back(e);
			next_id++;
		end
	endtask

	// run limit
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles with %0d edges and %0d commands outstanding",
				cycles, exp_edges.size(), exp_cmds.size());
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// memory responses and back-pressure
	////////////////////////////////////////////////////////////////////////////
	always @(posedge clock) begin
		int ready_n;
		int pick;
		int sel;
		if (rstn) begin
			ready_n = 0;
			sel     = 0;
			for (int i = 0; i < pend_due.size(); i++)
				if (pend_due[i] <= cycles)
					ready_n++;
			read_resp <= '0;
			if (ready_n > 0) begin
				pick = int'($unsigned($random(seed)) % ready_n);    // shuffles due answers
				for (int i = 0; i < pend_due.size(); i++) begin
					if (pend_due[i] <= cycles) begin
						if (pick == 0)
							sel = i;
						pick--;
					end
				end
				read_resp <= line_response(pend_cmds[sel]);
				pend_cmds.delete(sel);
				pend_due.delete(sel);
			end

			if (!req_random) begin
				edge_request <= 1'b1;
			end else if (req_hold == 0) begin
				edge_request <= ($unsigned($random(seed)) % 3) == 0;    // mostly low
				req_hold      = 1 + int'($unsigned($random(seed)) % 40);
			end else begin
				req_hold--;
			end

			if (rbf_toggle)
				read_buffer_full <= ($unsigned($random(seed)) % 3) == 0;
			else
				read_buffer_full <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// output monitor
	////////////////////////////////////////////////////////////////////////////
	always @(negedge clock) begin
		edge_pkg::read_cmd_t exp_cmd;
		edge_pkg::edge_job_t exp_edge;
		if (rstn) begin
			if (read_cmd.valid) begin
				cmds_seen++;
				checks++;
				pend_cmds.push_back(read_cmd);
				pend_due.push_back(cycles + int'($unsigned($random(seed)) % 6));    // 1 to 6 later
				if (exp_cmds.size() == 0) begin
					$display("unexpected read command to address %h at %0t",
						read_cmd.address, $time);
					errors++;
				end else begin
					exp_cmd = exp_cmds.pop_front();
					if (read_cmd !== exp_cmd) begin
						$display("ERROR at %0t: read command %h tag %h, expected %h tag %h",
							$time, read_cmd.address, read_cmd.tag, exp_cmd.address, exp_cmd.tag);
						errors++;
					end
				end
			end
			if (edge_job.valid) begin
				checks++;
				if (exp_edges.size() == 0) begin
					$display("edge id %0d arrived at %0t with no edge outstanding",
						edge_job.id, $time);
					errors++;
				end else begin
					exp_edge = exp_edges.pop_front();
					if (edge_job !== exp_edge) begin
						$display("ERROR at %0t: edge id %0d %h %h %h, expected id %0d %h %h %h",
							$time, edge_job.id, edge_job.src, edge_job.dest, edge_job.weight,
							exp_edge.id, exp_edge.src, exp_edge.dest, exp_edge.weight);
						errors++;
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		int row_errors;
		seed             = 32'hc968_0803;
		cfg              = '{48'h0001_0000_0000, 48'h0002_0000_0040, 48'h0003_0000_1000};
		vertex_job       = '0;
		read_buffer_full = 1'b0;
		read_resp        = '0;
		edge_request     = 1'b0;
		cycle_limit      = 200;
		for (int r = 0; r < row_count; r++)
			cycle_limit += 40 * int'(rows[r].degree) + 50 * int'(rows[r].chunks);
		for (int a = 0; a < 3; a++)
			for (int w = 0; w < mem_words; w++)
				mem[a][w] = $random(seed);

		repeat (2) @(posedge clock);
		rstn <= 1'b1;

		@(negedge clock);
		checks++;
		if (read_cmd.valid || edge_job.valid || !vertex_job_request || !edge_buffer_empty) begin
			$display("ERROR at %0t: after reset cmd %b edge %b request %b empty %b", $time,
				read_cmd.valid, edge_job.valid, vertex_job_request, edge_buffer_empty);
			errors++;
		end

		for (int r = 0; r < row_count; r++) begin
			row_errors = errors;
			cmds_seen  = 0;
			while (!vertex_job_request)
				@(negedge clock);
			req_random = rows[r].req_random;
			rbf_toggle = rows[r].rbf_toggle;
			expect_row(rows[r]);
			@(posedge clock);
			vertex_job <= '{valid: 1'b1, edges_idx: rows[r].edges_idx, degree: rows[r].degree};
			@(posedge clock);
			vertex_job <= '0;
			if (rows[r].degree == 0) begin
				repeat (10) @(negedge clock);
				checks++;
				if (!vertex_job_request) begin
					$display("vertex_job_request went low on a job with no edges");
					errors++;
				end
			end
			do
				@(negedge clock);
			while (exp_edges.size() != 0 || exp_cmds.size() != 0 || !vertex_job_request);
			checks++;
			if (cmds_seen != 3 * int'(rows[r].chunks)) begin
				$display("ERROR at %0t: row %0d sent %0d commands, expected %0d", $time, r,
					cmds_seen, 3 * int'(rows[r].chunks));
				errors++;
			end
			$display("row %0d idx %0d degree %0d: %s", r, rows[r].edges_idx, rows[r].degree,
				(errors == row_errors) ? "ok" : "failed");
		end

		$display("rows %0d, checks %0d, errors %0d", row_count, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* tests/edge_fetch_props.sv */
`timescale 1ns/1ns

module edge_fetch_props (
	input logic                clock,
	input logic                rstn,
	input edge_pkg::read_cmd_t read_cmd,
	input logic                edge_request,
	input logic                edge_valid,
	input logic                push_valid,
	input logic                fifo_full,
	input logic                chunk_done
);

	logic [2:0] cmds_in_chunk;    // commands since the last chunk_done

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			cmds_in_chunk <= '0;
		else if (chunk_done)
			cmds_in_chunk <= {2'b00, read_cmd.valid};
		else if (read_cmd.valid)
			cmds_in_chunk <= cmds_in_chunk + 3'd1;
	end

	line_aligned: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd.valid |-> (read_cmd.address[5:0] == 6'd0))
		else $error("read command address %h not on a line boundary", read_cmd.address);

	no_push_when_full: assert property (@(posedge clock) disable iff (!rstn)
		push_valid |-> !fifo_full)
		else $error("edge pushed into a full FIFO");

	pop_after_request: assert property (@(posedge clock) disable iff (!rstn)
		edge_valid |-> $past(edge_request))
		else $error("edge_job valid without edge_request a cycle earlier");

	three_cmds_per_chunk: assert property (@(posedge clock) disable iff (!rstn)
		cmds_in_chunk <= 3'(edge_pkg::max_outstanding))
		else $error("more than three read commands in one chunk");

endmodule

bind edge_fetch_top edge_fetch_props props_i (
	.clock        (clock),
	.rstn         (rstn),
	.read_cmd     (read_cmd),
	.edge_request (edge_request),
	.edge_valid   (edge_job.valid),
	.push_valid   (push_edge.valid),
	.fifo_full    (fifo_full),
	.chunk_done   (chunk_done)
);

/* logic/edge_fetch_top.sv */
`timescale 1ns/1ns

module edge_fetch_top (
	input  logic                    clock,
	input  logic                    rstn,
	input  edge_pkg::fetch_config_t cfg,
	input  edge_pkg::vertex_job_t   vertex_job,
	output logic                    vertex_job_request,
	output edge_pkg::read_cmd_t     read_cmd,
	input  logic                    read_buffer_full,
	input  edge_pkg::read_resp_t    read_resp,
	input  logic                    edge_request,
	output edge_pkg::edge_job_t     edge_job,
	output logic                    edge_buffer_empty
);

	logic [edge_pkg::lane_count-1:0] lane_load;
	logic [edge_pkg::lane_count-1:0] lane_ready;
	logic [edge_pkg::line_bits-1:0]  lane_line;
	edge_pkg::read_tag_t             lane_tag;
	logic [edge_pkg::edge_bits-1:0]  lane_head [edge_pkg::lane_count];
	logic                            stream_shift;
	logic                            chunk_done;
	logic                            fifo_almost_full;
	logic                            fifo_full;
	edge_pkg::edge_job_t             push_edge;

	edge_read_sequencer seq_i (
		.clock              (clock),
		.rstn               (rstn),
		.cfg                (cfg),
		.vertex_job         (vertex_job),
		.read_buffer_full   (read_buffer_full),
		.fifo_almost_full   (fifo_almost_full),
		.chunk_done         (chunk_done),
		.vertex_job_request (vertex_job_request),
		.read_cmd           (read_cmd)
	);

	response_router router_i (
		.clock     (clock),
		.rstn      (rstn),
		.read_resp (read_resp),
		.lane_load (lane_load),
		.lane_line (lane_line),
		.lane_tag  (lane_tag)
	);

	////////////////////////////////////////////////////////////////////////////
	// one stream per edge array
	////////////////////////////////////////////////////////////////////////////
	for (genvar g = int'(edge_pkg::array_src); g <= int'(edge_pkg::array_weight); g++) begin : g_lane
		cacheline_stream stream_i (
			.clock (clock),
			.rstn  (rstn),
			.load  (lane_load[g]),
			.line  (lane_line),
			.tag   (lane_tag),
			.shift (stream_shift),
			.clear (chunk_done),
			.ready (lane_ready[g]),
			.head  (lane_head[g])
		);
	end

	edge_assembler asm_i (
		.clock       (clock),
		.rstn        (rstn),
		.lane_ready  (lane_ready),
		.src_head    (lane_head[edge_pkg::array_src]),
		.dest_head   (lane_head[edge_pkg::array_dest]),
		.weight_head (lane_head[edge_pkg::array_weight]),
		.count       (lane_tag.count),    // same in all three tags of a chunk
		.shift       (stream_shift),
		.chunk_done  (chunk_done),
		.push_edge   (push_edge)
	);

	edge_job_fifo fifo_i (
		.clock       (clock),
		.rstn        (rstn),
		.push        (push_edge),
		.pop         (edge_request),
		.almost_full (fifo_almost_full),
		.full        (fifo_full),
		.empty       (edge_buffer_empty),
		.data_out    (edge_job)
	);

endmodule

/* logic/edge_job_fifo.sv */
`timescale 1ns/1ns

module edge_job_fifo (
	input  logic                clock,
	input  logic                rstn,
	input  edge_pkg::edge_job_t push,
	input  logic                pop,
	output logic                almost_full,
	output logic                full,
	output logic                empty,
	output edge_pkg::edge_job_t data_out
);

	edge_pkg::edge_job_t mem [edge_pkg::fifo_depth];

	logic [edge_pkg::fifo_ptr_bits-1:0]   wr_ptr;
	logic [edge_pkg::fifo_ptr_bits-1:0]   rd_ptr;
	logic [edge_pkg::fifo_count_bits-1:0] used;
	logic                                 push_ok;
	logic                                 pop_ok;

	assign full        = (used == edge_pkg::fifo_full_used);
	assign empty       = (used == '0);
	assign almost_full = (used > edge_pkg::fifo_af_used);    // under a line of room
	assign push_ok     = push.valid && !full;
	assign pop_ok      = pop && !empty;

	always_ff @(posedge clock) begin
		if (push_ok)
			mem[wr_ptr] <= push;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			used     <= '0;
			data_out <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1;    // wraps at depth
			if (pop_ok)
				rd_ptr <= rd_ptr + 1;

			case ({push_ok, pop_ok})
				2'b10:   used <= used + 1;
				2'b01:   used <= used - 1;
				default: used <= used;
			endcase

			if (pop_ok)
				data_out <= mem[rd_ptr];
			else
				data_out.valid <= 1'b0;
		end
	end

endmodule

/* logic/edge_assembler.sv */
`timescale 1ns/1ns

module edge_assembler (
	input  logic                             clock,
	input  logic                             rstn,
	input  logic [edge_pkg::lane_count-1:0]  lane_ready,
	input  logic [edge_pkg::edge_bits-1:0]   src_head,
	input  logic [edge_pkg::edge_bits-1:0]   dest_head,
	input  logic [edge_pkg::edge_bits-1:0]   weight_head,
	input  logic [edge_pkg::chunk_bits-1:0]  count,
	output logic                             shift,
	output logic                             chunk_done,
	output edge_pkg::edge_job_t              push_edge
);

	logic [edge_pkg::chunk_bits-1:0] sent;       // records of this chunk so far
	logic [edge_pkg::count_bits-1:0] next_id;
	logic                            all_ready;
	logic                            last_sent;

	assign all_ready = &lane_ready;
	assign last_sent = (sent == count);
	assign shift     = all_ready && !last_sent;    // streams step in lockstep

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sent       <= '0;
			next_id    <= '0;
			chunk_done <= 1'b0;
			push_edge  <= '0;
		end else begin
			push_edge.valid <= shift;
			if (shift) begin
				push_edge.id     <= next_id;
				push_edge.src    <= src_head;
				push_edge.dest   <= dest_head;
				push_edge.weight <= weight_head;
				next_id          <= next_id + 1;
				sent             <= sent + 1;
			end else if (chunk_done) begin
				sent <= '0;
			end

			// one pulse, the cycle after the last push
			chunk_done <= all_ready && last_sent && !chunk_done;
		end
	end

endmodule

/* logic/cacheline_stream.sv */
`timescale 1ns/1ns

module cacheline_stream (
	input  logic                            clock,
	input  logic                            rstn,
	input  logic                            load,
	input  logic [edge_pkg::line_bits-1:0]  line,
	input  edge_pkg::read_tag_t             tag,
	input  logic                            shift,
	input  logic                            clear,
	output logic                            ready,
	output logic [edge_pkg::edge_bits-1:0]  head
);

	logic [edge_pkg::line_bits-1:0] line_q;    // edge k sits at bits [32k +: 32]

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ready <= 1'b0;
		end else begin
			if (clear)
				ready <= 1'b0;
			else if (load)
				ready <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// line shifter
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (load) begin
			// skip the edges ahead of the start index
			line_q <= line >> (tag.offset * edge_pkg::edge_bits);
		end else if (shift) begin
			line_q <= line_q >> edge_pkg::edge_bits;
		end
	end

	assign head = line_q[edge_pkg::edge_bits-1:0];

endmodule

/* logic/response_router.sv */
`timescale 1ns/1ns

module response_router (
	input  logic                                clock,
	input  logic                                rstn,
	input  edge_pkg::read_resp_t                read_resp,
	output logic [edge_pkg::lane_count-1:0]     lane_load,
	output logic [edge_pkg::line_bits-1:0]      lane_line,
	output edge_pkg::read_tag_t                 lane_tag
);

	logic resp_valid;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			resp_valid <= 1'b0;
		else
			resp_valid <= read_resp.valid;
	end

	// line and tag are held until the next response
	// so the chunk count stays readable while the lanes drain
	always_ff @(posedge clock) begin
		if (read_resp.valid) begin
			lane_line <= read_resp.data;
			lane_tag  <= read_resp.tag;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// tag to one-hot lane strobe
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		lane_load = '0;
		for (int i = 0; i < edge_pkg::lane_count; i++) begin
			lane_load[i] = resp_valid && (lane_tag.array == edge_pkg::edge_array_t'(i));
		end
	end

endmodule

/* logic/edge_read_sequencer.sv */
`timescale 1ns/1ns

module edge_read_sequencer (
	input  logic                    clock,
	input  logic                    rstn,
	input  edge_pkg::fetch_config_t cfg,
	input  edge_pkg::vertex_job_t   vertex_job,
	input  logic                    read_buffer_full,
	input  logic                    fifo_almost_full,
	input  logic                    chunk_done,
	output logic                    vertex_job_request,
	output edge_pkg::read_cmd_t     read_cmd
);

	edge_pkg::seq_state_t state, next_state;

	logic [edge_pkg::idx_bits-1:0]   edge_idx;     // next edge to fetch
	logic [edge_pkg::count_bits-1:0] remaining;

	// chunk snapshot for the dest and weight commands
	logic [edge_pkg::offset_bits-1:0] chunk_offset;
	logic [edge_pkg::chunk_bits-1:0]  chunk_count;
	logic [edge_pkg::addr_bits-1:0]   chunk_bytes;

	logic [edge_pkg::offset_bits-1:0] first_c;
	logic [edge_pkg::chunk_bits-1:0]  room_c;
	logic [edge_pkg::chunk_bits-1:0]  count_c;
	logic [edge_pkg::addr_bits-1:0]   bytes_c;
	logic                             can_start;
	logic                             job_accept;

	function automatic edge_pkg::read_cmd_t make_cmd(
		input edge_pkg::edge_array_t            array,
		input logic [edge_pkg::addr_bits-1:0]   base,
		input logic [edge_pkg::addr_bits-1:0]   bytes,
		input logic [edge_pkg::offset_bits-1:0] offset,
		input logic [edge_pkg::chunk_bits-1:0]  count
	);
		edge_pkg::read_cmd_t cmd;
		cmd.valid      = 1'b1;
		cmd.op         = edge_pkg::op_read_line;
		cmd.address    = (base + bytes) & edge_pkg::line_mask;    // round down to the line
		cmd.tag.array  = array;
		cmd.tag.offset = offset;
		cmd.tag.count  = count;
		return cmd;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// chunk math
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		first_c = edge_idx[edge_pkg::offset_bits-1:0];
		room_c  = edge_pkg::chunk_full - {1'b0, first_c};    // edges left in this line
		if (remaining < {{(edge_pkg::count_bits - edge_pkg::chunk_bits){1'b0}}, room_c})
			count_c = remaining[edge_pkg::chunk_bits-1:0];
		else
			count_c = room_c;
		bytes_c = {{edge_pkg::idx_pad_bits{1'b0}}, edge_idx, {edge_pkg::edge_bytes_log2{1'b0}}};
	end

	assign vertex_job_request = (state == edge_pkg::s_idle) && (remaining == '0);
	assign job_accept         = vertex_job_request && vertex_job.valid;
	// only looked at in s_idle, after the previous chunk closed
	assign can_start          = (remaining != '0) && !fifo_almost_full && !read_buffer_full;

	////////////////////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		next_state = state;
		case (state)
			edge_pkg::s_idle: begin
				if (can_start)
					next_state = edge_pkg::s_calc;
			end
			edge_pkg::s_calc:   next_state = edge_pkg::s_src;
			edge_pkg::s_src:    next_state = edge_pkg::s_dest;
			edge_pkg::s_dest:   next_state = edge_pkg::s_weight;
			edge_pkg::s_weight: next_state = edge_pkg::s_wait;
			edge_pkg::s_wait: begin
				if (chunk_done)    // all records of the chunk pushed
					next_state = edge_pkg::s_idle;
			end
			default: next_state = edge_pkg::s_idle;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= edge_pkg::s_idle;
			edge_idx  <= '0;
			remaining <= '0;
			read_cmd  <= '0;
		end else begin
			state          <= next_state;
			read_cmd.valid <= 1'b0;    // one cycle strobe

			case (state)
				edge_pkg::s_idle: begin
					if (job_accept) begin
						edge_idx  <= vertex_job.edges_idx;
						remaining <= vertex_job.degree;    // degree 0 stays idle
					end
				end
				edge_pkg::s_calc: begin
					edge_idx  <= edge_idx + {{(edge_pkg::idx_bits - edge_pkg::chunk_bits){1'b0}},
						count_c};
					remaining <= remaining -
						{{(edge_pkg::count_bits - edge_pkg::chunk_bits){1'b0}}, count_c};
					read_cmd  <= make_cmd(edge_pkg::array_src, cfg.src_base, bytes_c,
						first_c, count_c);
				end
				edge_pkg::s_src: begin
					read_cmd <= make_cmd(edge_pkg::array_dest, cfg.dest_base, chunk_bytes,
						chunk_offset, chunk_count);
				end
				edge_pkg::s_dest: begin
					read_cmd <= make_cmd(edge_pkg::array_weight, cfg.weight_base, chunk_bytes,
						chunk_offset, chunk_count);
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == edge_pkg::s_calc) begin
			chunk_offset <= first_c;
			chunk_count  <= count_c;
			chunk_bytes  <= bytes_c;
		end
	end

endmodule

/* logic/edge_pkg.sv */
package edge_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////////////////////
	localparam int edge_bits       = 32;
	localparam int line_bits       = 512;
	localparam int line_edges      = 16;
	localparam int line_bytes      = 64;
	localparam int offset_bits     = 4;                  // edge index inside a line
	localparam int chunk_bits      = offset_bits + 1;    // 1..16 edges used from a line
	localparam int addr_bits       = 48;
	localparam int idx_bits        = 32;
	localparam int count_bits      = 16;                 // degrees, chunk counts, ids
	localparam int edge_bytes_log2 = 2;
	localparam int idx_pad_bits    = addr_bits - idx_bits - edge_bytes_log2;
	localparam int lane_count      = 3;

	localparam int fifo_depth      = 32;                 // two full lines
	localparam int fifo_margin     = line_edges;
	localparam int fifo_ptr_bits   = $clog2(fifo_depth);
	localparam int fifo_count_bits = fifo_ptr_bits + 1;

	localparam logic [1:0] max_outstanding = 2'd3;      // one command per array

	// sized forms for compares against narrow counters
	localparam logic [chunk_bits-1:0]      chunk_full     = chunk_bits'(line_edges);
	localparam logic [addr_bits-1:0]       line_mask      = ~addr_bits'(line_bytes - 1);
	localparam logic [fifo_count_bits-1:0] fifo_full_used = fifo_count_bits'(fifo_depth);
	localparam logic [fifo_count_bits-1:0] fifo_af_used   =
		fifo_count_bits'(fifo_depth - fifo_margin);

	////////////////////////////////////////////////////////////////////////////
	// encodings
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {
		array_src,
		array_dest,
		array_weight
	} edge_array_t;    // tag value and lane index at once

	typedef enum logic [1:0] {
		op_none,
		op_read_line
	} read_op_t;

	typedef enum logic [2:0] {
		s_idle,
		s_calc,
		s_src,
		s_dest,
		s_weight,
		s_wait
	} seq_state_t;

	typedef struct packed {
		logic [addr_bits-1:0] src_base;
		logic [addr_bits-1:0] dest_base;
		logic [addr_bits-1:0] weight_base;
	} fetch_config_t;

	typedef struct packed {
		logic                  valid;
		logic [idx_bits-1:0]   edges_idx;
		logic [count_bits-1:0] degree;
	} vertex_job_t;

	typedef struct packed {
		edge_array_t            array;
		logic [offset_bits-1:0] offset;    // first useful edge in the line
		logic [chunk_bits-1:0]  count;     // edges taken from the line
	} read_tag_t;

	typedef struct packed {
		logic                 valid;
		read_op_t             op;
		logic [addr_bits-1:0] address;
		read_tag_t            tag;
	} read_cmd_t;

	typedef struct packed {
		logic                 valid;
		read_tag_t            tag;
		logic [line_bits-1:0] data;
	} read_resp_t;

	typedef struct packed {
		logic                  valid;
		logic [count_bits-1:0] id;
		logic [edge_bits-1:0]  src;
		logic [edge_bits-1:0]  dest;
		logic [edge_bits-1:0]  weight;
	} edge_job_t;

endpackage
